// File: i3c_hci_pkg.sv
/* I3C HCI shared definitions */
package i3c_hci_pkg;

  // Bus and field widths
  localparam int unsigned CsrAddrWidth = 12;
  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned DevAddrWidth = 7;
  localparam int unsigned ThldWidth    = 8;

  // Register map
  localparam logic [CsrAddrWidth-1:0] CsrResetCtrl    = 12'h010;
  localparam logic [CsrAddrWidth-1:0] CsrCommandPort  = 12'h080;
  localparam logic [CsrAddrWidth-1:0] CsrResponsePort = 12'h084;
  localparam logic [CsrAddrWidth-1:0] CsrQueueThld    = 12'h090;
  localparam logic [CsrAddrWidth-1:0] CsrStaticAddr   = 12'h1c0;
  localparam logic [CsrAddrWidth-1:0] CsrDevAddr      = 12'h1c4;

  // RESET_CONTROL bit positions
  localparam int unsigned RstCmdBit  = 0;
  localparam int unsigned RstRespBit = 1;

  // Command descriptor, two DWORDs written low first
  typedef struct packed {
    logic [CsrDataWidth-1:0] hi;
    logic [CsrDataWidth-1:0] lo;
  } cmd_desc_t;

  typedef logic [CsrDataWidth-1:0] resp_desc_t;

  // One bit per register
  typedef struct packed {
    logic reset_ctrl;
    logic queue_thld;
    logic command_port;
    logic response_port;
    logic static_addr;
    logic dev_addr;
    logic hit;       // Any register matched
  } csr_sel_t;

  // Valid flag sits above the address, matching the register layout
  typedef struct packed {
    logic                    valid;
    logic [DevAddrWidth-1:0] addr;
  } dev_addr_t;

endpackage : i3c_hci_pkg

// File: hci_queue_if.sv
/* Queue access interface */
`timescale 1ns/100ps

interface hci_queue_if
  import i3c_hci_pkg::*;
#(
  parameter type         T        = logic [CsrDataWidth-1:0],
  parameter int unsigned CntWidth = 4
) ();

  // Producer and control side
  logic                 push_valid;
  T                     push_data;
  logic                 pop;
  logic                 flush;
  logic [ThldWidth-1:0] thld;

  // Queue status
  T                     head;
  logic [CntWidth-1:0]  depth;
  logic                 full;
  logic                 empty;
  logic                 trig;

  modport csr (
    output push_valid, push_data, pop, flush, thld,
    input  head, depth, full, empty, trig
  );

  modport queue (
    input  push_valid, push_data, pop, flush, thld,
    output head, depth, full, empty, trig
  );

endinterface : hci_queue_if

// File: hci_csr_decode.sv
/* HCI CSR write decoder */
`timescale 1ns/100ps

module hci_csr_decode
  import i3c_hci_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      req_i,
  input  logic                      req_is_wr_i,
  input  logic [CsrAddrWidth-1:0]   addr_i,
  input  logic [CsrDataWidth-1:0]   wr_data_i,

  output logic                      req_stall_wr_o,
  output logic                      wr_ack_o,
  output csr_sel_t                  sel_o,
  output logic                      rd_req_o,

  hci_queue_if.csr                  cmd_q,
  hci_queue_if.csr                  resp_q,

  output logic [2*ThldWidth-1:0]    thld_reg_o,
  output logic [1:0]                rst_reg_o,
  output dev_addr_t                 static_addr_o,
  output dev_addr_t                 virt_static_addr_o
);

  logic                    wr_acc;
  logic                    cmd_wr;
  logic                    wr_ack_q;
  logic                    phase_q;  // Low DWORD already held
  logic [CsrDataWidth-1:0] cmd_lo_q;
  logic [2*ThldWidth-1:0]  thld_q;
  logic [1:0]              rst_q;
  dev_addr_t               static_q;
  dev_addr_t               virt_static_q;

  always_comb begin
    sel_o = '0;
    case (addr_i)
      CsrResetCtrl:    sel_o.reset_ctrl    = 1'b1;
      CsrQueueThld:    sel_o.queue_thld    = 1'b1;
      CsrCommandPort:  sel_o.command_port  = 1'b1;
      CsrResponsePort: sel_o.response_port = 1'b1;
      CsrStaticAddr:   sel_o.static_addr   = 1'b1;
      CsrDevAddr:      sel_o.dev_addr      = 1'b1;
      default: ;
    endcase
    sel_o.hit = sel_o.reset_ctrl | sel_o.queue_thld | sel_o.command_port |
                sel_o.response_port | sel_o.static_addr | sel_o.dev_addr;
  end

  // Hold software off while there is no room for another descriptor
  assign req_stall_wr_o = req_i & req_is_wr_i & sel_o.command_port & cmd_q.full;
  assign wr_acc         = req_i & req_is_wr_i & ~req_stall_wr_o;
  assign cmd_wr         = wr_acc & sel_o.command_port;
  assign rd_req_o       = req_i & ~req_is_wr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ack_q      <= 1'b0;
      phase_q       <= 1'b0;
      thld_q        <= {ThldWidth'(1), ThldWidth'(1)};
      rst_q         <= '0;
      static_q      <= '0;
      virt_static_q <= '0;
    end else begin
      wr_ack_q <= wr_acc;
      rst_q    <= (wr_acc && sel_o.reset_ctrl) ? wr_data_i[1:0] : 2'b00;  // Self-clearing
      if (wr_acc && sel_o.queue_thld) begin
        thld_q <= wr_data_i[2*ThldWidth-1:0];
      end
      if (wr_acc && sel_o.static_addr) begin
        static_q      <= '{valid: 1'b1, addr: wr_data_i[DevAddrWidth-1:0]};
        virt_static_q <= '{valid: 1'b1, addr: wr_data_i[8 +: DevAddrWidth]};
      end
      if (rst_q[RstCmdBit]) begin
        phase_q <= 1'b0;  // Drop a half-written descriptor
      end else if (cmd_wr) begin
        phase_q <= ~phase_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr && !phase_q) begin
      cmd_lo_q <= wr_data_i;
    end
  end

  assign cmd_q.push_valid = cmd_wr & phase_q;
  assign cmd_q.push_data  = {wr_data_i, cmd_lo_q};
  assign cmd_q.flush      = rst_q[RstCmdBit];
  assign cmd_q.thld       = thld_q[ThldWidth-1:0];

  assign resp_q.pop   = rd_req_o & sel_o.response_port & (resp_q.depth != '0);
  assign resp_q.flush = rst_q[RstRespBit];
  assign resp_q.thld  = thld_q[2*ThldWidth-1:ThldWidth];

  assign wr_ack_o           = wr_ack_q;
  assign thld_reg_o         = thld_q;
  assign rst_reg_o          = rst_q;
  assign static_addr_o      = static_q;
  assign virt_static_addr_o = virt_static_q;

endmodule : hci_csr_decode

// File: hci_queue.sv
/* Flushable descriptor queue */
`timescale 1ns/100ps

module hci_queue
  import i3c_hci_pkg::*;
#(
  parameter type         T          = logic [CsrDataWidth-1:0],
  parameter int unsigned Depth      = 8,
  parameter bit          TrigOnFree = 1'b0
) (
  input logic        clk_i,
  input logic        rst_ni,
  hci_queue_if.queue q
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam int unsigned CmpWidth = (CntWidth > ThldWidth) ? CntWidth : ThldWidth;

  T                     mem [Depth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  cnt_q;
  logic [CntWidth-1:0]  level;
  logic [ThldWidth-1:0] thld_eff;
  logic                 trig_q;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    ptr_inc = (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Free slots or occupied entries
  assign level    = TrigOnFree ? CntWidth'(Depth) - cnt_q : cnt_q;
  assign thld_eff = (q.thld == '0) ? ThldWidth'(1) : q.thld;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      trig_q   <= 1'b0;
    end else begin
      trig_q <= CmpWidth'(level) >= CmpWidth'(thld_eff);
      if (q.flush) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (q.push_valid) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (q.pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        case ({q.push_valid, q.pop})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (q.push_valid) begin
      mem[wr_ptr_q] <= q.push_data;
    end
  end

  assign q.head  = mem[rd_ptr_q];
  assign q.depth = cnt_q;
  assign q.full  = (cnt_q == CntWidth'(Depth));
  assign q.empty = (cnt_q == '0);
  assign q.trig  = trig_q;

endmodule : hci_queue

// File: hci_addr_ctrl.sv
/* Target address assignment */
`timescale 1ns/100ps

module hci_addr_ctrl
  import i3c_hci_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic [DevAddrWidth-1:0] set_dasa_i,
  input  logic                    set_dasa_valid_i,
  input  logic                    set_dasa_virt_i,
  input  logic                    rstdaa_i,
  input  logic [DevAddrWidth-1:0] newda_i,
  input  logic                    set_newda_i,
  input  logic                    set_newda_virt_i,
  input  logic                    set_aasa_i,
  input  logic                    set_aasa_virt_i,

  input  dev_addr_t               static_addr_i,
  input  dev_addr_t               virt_static_addr_i,

  output dev_addr_t               dyn_addr_o,
  output dev_addr_t               virt_dyn_addr_o
);

  dev_addr_t dyn_q;
  dev_addr_t virt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dyn_q  <= '0;
      virt_q <= '0;
    end else if (rstdaa_i || set_dasa_valid_i) begin
      if (rstdaa_i) begin
        dyn_q  <= '0;
        virt_q <= '0;
      end else if (set_dasa_virt_i) begin
        virt_q <= '{valid: 1'b1, addr: set_dasa_i};
      end else begin
        dyn_q <= '{valid: 1'b1, addr: set_dasa_i};
      end
    end else if (set_newda_i) begin
      if (set_newda_virt_i) begin
        virt_q <= '{valid: 1'b1, addr: newda_i};
      end else begin
        dyn_q <= '{valid: 1'b1, addr: newda_i};
      end
    end else begin
      if (set_aasa_i && static_addr_i.valid) begin
        dyn_q <= '{valid: 1'b1, addr: static_addr_i.addr};
      end
      if (set_aasa_virt_i && virt_static_addr_i.valid) begin
        virt_q <= '{valid: 1'b1, addr: virt_static_addr_i.addr};
      end
    end
  end

  assign dyn_addr_o      = dyn_q;
  assign virt_dyn_addr_o = virt_q;

endmodule : hci_addr_ctrl

// File: hci_csr_readback.sv
/* CSR read path */
`timescale 1ns/100ps

module hci_csr_readback
  import i3c_hci_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    rd_req_i,
  input  csr_sel_t                sel_i,
  input  logic [2*ThldWidth-1:0]  thld_reg_i,
  input  logic [1:0]              rst_reg_i,
  input  dev_addr_t               static_addr_i,
  input  dev_addr_t               virt_static_addr_i,
  input  dev_addr_t               dyn_addr_i,
  input  dev_addr_t               virt_dyn_addr_i,
  input  resp_desc_t              resp_head_i,
  input  logic                    resp_empty_i,

  output logic                    rd_ack_o,
  output logic                    rd_err_o,
  output logic [CsrDataWidth-1:0] rd_data_o
);

  logic [CsrDataWidth-1:0] rd_data;
  logic                    rd_err;
  logic                    rd_ack_q;
  logic                    rd_err_q;
  logic [CsrDataWidth-1:0] rd_data_q;

  always_comb begin
    rd_data = '0;
    if (sel_i.reset_ctrl) begin
      rd_data = {{(CsrDataWidth-2){1'b0}}, rst_reg_i};
    end else if (sel_i.queue_thld) begin
      rd_data = {{(CsrDataWidth-2*ThldWidth){1'b0}}, thld_reg_i};
    end else if (sel_i.response_port && !resp_empty_i) begin
      rd_data = resp_head_i;
    end else if (sel_i.static_addr) begin
      rd_data = {17'b0, virt_static_addr_i.addr, 1'b0, static_addr_i.addr};
    end else if (sel_i.dev_addr) begin
      rd_data = {16'b0, virt_dyn_addr_i, dyn_addr_i};
    end
  end

  // Unmapped address or response underflow
  assign rd_err = ~sel_i.hit | (sel_i.response_port & resp_empty_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_req_i;
      rd_err_q <= rd_req_i & rd_err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      rd_data_q <= rd_data;
    end
  end

  assign rd_ack_o  = rd_ack_q;
  assign rd_err_o  = rd_err_q;
  assign rd_data_o = rd_data_q;

endmodule : hci_csr_readback

// File: hci_top.sv
/* I3C HCI queues and CSRs */
`timescale 1ns/100ps

module hci_top
  import i3c_hci_pkg::*;
#(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // CSR port
  input  logic                    req_i,
  input  logic                    req_is_wr_i,
  input  logic [CsrAddrWidth-1:0] addr_i,
  input  logic [CsrDataWidth-1:0] wr_data_i,
  output logic                    req_stall_wr_o,
  output logic                    rd_ack_o,
  output logic                    rd_err_o,
  output logic [CsrDataWidth-1:0] rd_data_o,
  output logic                    wr_ack_o,

  // Controller side
  output logic                    cmd_rvalid_o,
  input  logic                    cmd_rready_i,
  output cmd_desc_t               cmd_rdata_o,
  input  logic                    resp_wvalid_i,
  output logic                    resp_wready_o,
  input  resp_desc_t              resp_wdata_i,

  output logic                    cmd_thld_trig_o,
  output logic                    resp_thld_trig_o,

  // CCC inputs
  input  logic [DevAddrWidth-1:0] set_dasa_i,
  input  logic                    set_dasa_valid_i,
  input  logic                    set_dasa_virt_i,
  input  logic                    rstdaa_i,
  input  logic [DevAddrWidth-1:0] newda_i,
  input  logic                    set_newda_i,
  input  logic                    set_newda_virt_i,
  input  logic                    set_aasa_i,
  input  logic                    set_aasa_virt_i
);

  localparam int unsigned CmdCntWidth  = $clog2(CmdDepth + 1);
  localparam int unsigned RespCntWidth = $clog2(RespDepth + 1);

  csr_sel_t               sel;
  logic                   rd_req;
  logic [2*ThldWidth-1:0] thld_reg;
  logic [1:0]             rst_reg;
  dev_addr_t              static_addr;
  dev_addr_t              virt_static_addr;
  dev_addr_t              dyn_addr;
  dev_addr_t              virt_dyn_addr;

  hci_queue_if #(.T(cmd_desc_t),  .CntWidth(CmdCntWidth))  cmd_q ();
  hci_queue_if #(.T(resp_desc_t), .CntWidth(RespCntWidth)) resp_q ();

  // Controller handshakes
  assign cmd_q.pop         = cmd_rready_i & ~cmd_q.empty;
  assign cmd_rvalid_o      = ~cmd_q.empty;
  assign cmd_rdata_o       = cmd_q.head;
  assign resp_q.push_valid = resp_wvalid_i & ~resp_q.full;
  assign resp_q.push_data  = resp_wdata_i;
  assign resp_wready_o     = ~resp_q.full;
  assign cmd_thld_trig_o   = cmd_q.trig;
  assign resp_thld_trig_o  = resp_q.trig;

  hci_csr_decode u_decode (
    .clk_i, .rst_ni,
    .req_i, .req_is_wr_i, .addr_i, .wr_data_i,
    .req_stall_wr_o, .wr_ack_o,
    .sel_o(sel), .rd_req_o(rd_req),
    .cmd_q(cmd_q.csr), .resp_q(resp_q.csr),
    .thld_reg_o(thld_reg), .rst_reg_o(rst_reg),
    .static_addr_o(static_addr), .virt_static_addr_o(virt_static_addr)
  );

  hci_queue #(.T(cmd_desc_t), .Depth(CmdDepth), .TrigOnFree(1'b1)) u_cmd_queue (
    .clk_i, .rst_ni, .q(cmd_q.queue)
  );

  hci_queue #(.T(resp_desc_t), .Depth(RespDepth), .TrigOnFree(1'b0)) u_resp_queue (
    .clk_i, .rst_ni, .q(resp_q.queue)
  );

  hci_addr_ctrl u_addr_ctrl (
    .clk_i, .rst_ni,
    .set_dasa_i, .set_dasa_valid_i, .set_dasa_virt_i, .rstdaa_i,
    .newda_i, .set_newda_i, .set_newda_virt_i, .set_aasa_i, .set_aasa_virt_i,
    .static_addr_i(static_addr), .virt_static_addr_i(virt_static_addr),
    .dyn_addr_o(dyn_addr), .virt_dyn_addr_o(virt_dyn_addr)
  );

  hci_csr_readback u_readback (
    .clk_i, .rst_ni,
    .rd_req_i(rd_req), .sel_i(sel),
    .thld_reg_i(thld_reg), .rst_reg_i(rst_reg),
    .static_addr_i(static_addr), .virt_static_addr_i(virt_static_addr),
    .dyn_addr_i(dyn_addr), .virt_dyn_addr_i(virt_dyn_addr),
    .resp_head_i(resp_q.head), .resp_empty_i(resp_q.empty),
    .rd_ack_o, .rd_err_o, .rd_data_o
  );

endmodule : hci_top

// File: tb_clk_gen.sv
/* Testbench clock and reset */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rst_no = 1'b1;
  end

endmodule : tb_clk_gen

// File: tb_hci_tasks.svh
/* HCI bus, compare and test tasks */
`ifndef TB_HCI_TASKS_SVH
`define TB_HCI_TASKS_SVH

task automatic check_cmd(input cmd_desc_t got, input cmd_desc_t exp, input string what);
  checks++;
  if (got !== exp) begin
    $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_resp(input resp_desc_t got, input resp_desc_t exp, input string what);
  checks++;
  if (got !== exp) begin
    $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_word(input logic [CsrDataWidth-1:0] got, input logic [CsrDataWidth-1:0] exp,
                          input string what);
  checks++;
  if (got !== exp) begin
    $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    $display("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic drive_idle();
  csr_req        = 1'b0;
  csr_we         = 1'b0;
  csr_addr       = '0;
  csr_wdata      = '0;
  cmd_rready     = 1'b0;
  resp_wvalid    = 1'b0;
  resp_wdata     = '0;
  set_dasa       = '0;
  set_dasa_valid = 1'b0;
  set_dasa_virt  = 1'b0;
  rstdaa         = 1'b0;
  newda          = '0;
  set_newda      = 1'b0;
  set_newda_virt = 1'b0;
  set_aasa       = 1'b0;
  set_aasa_virt  = 1'b0;
endtask

// Trigger outputs are registered
task automatic settle();
  repeat (2) @(negedge clk);
endtask

task automatic csr_write(input logic [CsrAddrWidth-1:0] waddr,
                         input logic [CsrDataWidth-1:0] wdata);
  @(negedge clk);
  csr_req   = 1'b1;
  csr_we    = 1'b1;
  csr_addr  = waddr;
  csr_wdata = wdata;
  #1;
  while (req_stall_wr) begin  // Hold until accepted
    @(negedge clk);
    #1;
  end
  @(negedge clk);
  csr_req = 1'b0;
  csr_we  = 1'b0;
  if (wr_ack !== 1'b1) begin
    $display("%0t: write to 0x%h was not acknowledged", $time, waddr);
    failures++;
  end
endtask

task automatic csr_read(input logic [CsrAddrWidth-1:0] raddr,
                        output logic [CsrDataWidth-1:0] rdata, output logic err);
  @(negedge clk);
  csr_req  = 1'b1;
  csr_we   = 1'b0;
  csr_addr = raddr;
  @(negedge clk);
  csr_req = 1'b0;
  if (rd_ack !== 1'b1) begin
    $display("%0t: read of 0x%h returned no acknowledge", $time, raddr);
    failures++;
  end
  rdata = rd_data;
  err   = rd_err;
endtask

task automatic write_cmd(input cmd_desc_t desc);
  csr_write(CsrCommandPort, desc.lo);
  csr_write(CsrCommandPort, desc.hi);
endtask

task automatic pop_cmd(output cmd_desc_t desc);
  @(negedge clk);
  while (cmd_rvalid !== 1'b1) @(negedge clk);
  desc       = cmd_rdata;
  cmd_rready = 1'b1;
  @(negedge clk);
  cmd_rready = 1'b0;
endtask

task automatic push_resp(input resp_desc_t data);
  @(negedge clk);
  while (resp_wready !== 1'b1) @(negedge clk);
  resp_wvalid = 1'b1;
  resp_wdata  = data;
  @(negedge clk);
  resp_wvalid = 1'b0;
endtask

task automatic end_ccc();
  @(negedge clk);
  drive_idle();
endtask

task automatic check_dev_addr(input dev_addr_t dyn, input dev_addr_t virt, input string what);
  logic [CsrDataWidth-1:0] data;
  logic                    err;
  csr_read(CsrDevAddr, data, err);
  check_flag(err, 1'b0, "device address read error");
  check_word(data, {16'h0, virt.valid, virt.addr, dyn.valid, dyn.addr}, what);
endtask

task automatic check_reset_values();
  @(negedge clk);
  check_flag(wr_ack, 1'b0, "write ack in reset");
  check_flag(rd_ack, 1'b0, "read ack in reset");
  check_flag(rd_err, 1'b0, "read error in reset");
  check_flag(req_stall_wr, 1'b0, "stall in reset");
  check_flag(cmd_rvalid, 1'b0, "command valid in reset");
  check_flag(cmd_trig, 1'b0, "command trigger in reset");
  check_flag(resp_trig, 1'b0, "response trigger in reset");
  check_flag(resp_wready, 1'b1, "response ready in reset");
endtask

task automatic cmd_path_test();
  cmd_desc_t exp_q[$];
  cmd_desc_t desc;
  cmd_desc_t got;
  for (int i = 0; i < 4; i++) begin
    desc.lo = lcg_next();
    desc.hi = lcg_next();
    write_cmd(desc);
    exp_q.push_back(desc);
    if (i == 0) begin
      check_flag(cmd_rvalid, 1'b1, "command valid after first descriptor");
    end
  end
  while (exp_q.size() > 0) begin
    pop_cmd(got);
    check_cmd(got, exp_q.pop_front(), "command order");
  end
endtask

task automatic back_pressure_test();
  cmd_desc_t exp_q[$];
  cmd_desc_t desc;
  cmd_desc_t got;
  for (int i = 0; i < Depth; i++) begin
    desc.lo = lcg_next();
    desc.hi = lcg_next();
    write_cmd(desc);
    exp_q.push_back(desc);
  end
  desc.lo = lcg_next();
  desc.hi = lcg_next();
  @(negedge clk);
  csr_req   = 1'b1;
  csr_we    = 1'b1;
  csr_addr  = CsrCommandPort;
  csr_wdata = desc.lo;
  #1;
  check_flag(req_stall_wr, 1'b1, "stall on full command queue");
  @(negedge clk);
  check_flag(wr_ack, 1'b0, "no write ack while stalled");
  got        = cmd_rdata;  // Free one slot while the write waits
  cmd_rready = 1'b1;
  @(negedge clk);
  cmd_rready = 1'b0;
  check_cmd(got, exp_q.pop_front(), "head popped during stall");
  #1;
  check_flag(req_stall_wr, 1'b0, "stall released after pop");
  @(negedge clk);
  csr_req = 1'b0;
  csr_we  = 1'b0;
  check_flag(wr_ack, 1'b1, "write ack after stall");
  csr_write(CsrCommandPort, desc.hi);
  exp_q.push_back(desc);
  while (exp_q.size() > 0) begin
    pop_cmd(got);
    check_cmd(got, exp_q.pop_front(), "command order after back-pressure");
  end
endtask

task automatic resp_path_test();
  resp_desc_t              exp_q[$];
  resp_desc_t              resp;
  logic [CsrDataWidth-1:0] data;
  logic                    err;
  for (int i = 0; i < 3; i++) begin
    resp = lcg_next();
    push_resp(resp);
    exp_q.push_back(resp);
  end
  while (exp_q.size() > 0) begin
    csr_read(CsrResponsePort, data, err);
    check_flag(err, 1'b0, "response read error");
    check_resp(data, exp_q.pop_front(), "response order");
  end
  csr_read(CsrResponsePort, data, err);
  check_flag(err, 1'b1, "read of empty response queue");
  check_word(data, '0, "data of empty response read");
endtask

task automatic thld_reset_test();
  logic [CsrDataWidth-1:0] data;
  logic                    err;
  cmd_desc_t               desc;
  cmd_desc_t               got;
  csr_read(CsrQueueThld, data, err);
  check_word(data, 32'h0000_0101, "threshold reset value");
  csr_write(CsrQueueThld, 32'h0000_0201);  // Response 2, command 1
  push_resp(lcg_next());
  settle();
  check_flag(resp_trig, 1'b0, "response trigger below threshold");
  push_resp(lcg_next());
  settle();
  check_flag(resp_trig, 1'b1, "response trigger at threshold");
  csr_write(CsrQueueThld, 32'h0000_0208);
  settle();
  check_flag(cmd_trig, 1'b1, "eight free command slots");
  desc.lo = lcg_next();
  desc.hi = lcg_next();
  write_cmd(desc);
  settle();
  check_flag(cmd_trig, 1'b0, "seven free command slots");
  csr_write(CsrCommandPort, lcg_next());  // Half a descriptor
  csr_write(CsrResetCtrl, 32'h0000_0003);
  settle();
  check_flag(cmd_rvalid, 1'b0, "command queue empty after reset");
  check_flag(cmd_trig, 1'b1, "command trigger after reset");
  check_flag(resp_trig, 1'b0, "response trigger after reset");
  csr_read(CsrResponsePort, data, err);
  check_flag(err, 1'b1, "response queue empty after reset");
  csr_read(CsrResetCtrl, data, err);
  check_word(data, '0, "reset bits read back");
  desc.lo = lcg_next();
  desc.hi = lcg_next();
  write_cmd(desc);
  pop_cmd(got);
  check_cmd(got, desc, "descriptor after flushed half write");
endtask

task automatic addr_test();
  logic [CsrDataWidth-1:0] data;
  logic                    err;
  dev_addr_t               dyn;
  dev_addr_t               virt;
  dev_addr_t               sa;
  dev_addr_t               vsa;
  dyn  = '{valid: 1'b0, addr: '0};
  virt = '{valid: 1'b0, addr: '0};
  sa   = '{valid: 1'b1, addr: 7'h21};
  vsa  = '{valid: 1'b1, addr: 7'h32};
  check_dev_addr(dyn, virt, "device addresses after reset");
  csr_write(CsrStaticAddr, 32'hffff_b2a1);  // Spare bits set, 0x32 and 0x21 in the fields
  csr_read(CsrStaticAddr, data, err);
  check_word(data, 32'h0000_3221, "static addresses");
  @(negedge clk);
  set_aasa      = 1'b1;
  set_aasa_virt = 1'b1;
  end_ccc();
  dyn  = sa;
  virt = vsa;
  check_dev_addr(dyn, virt, "SETAASA copies static addresses");
  @(negedge clk);
  newda          = 7'h45;
  set_newda      = 1'b1;
  set_newda_virt = 1'b1;
  end_ccc();
  virt = '{valid: 1'b1, addr: 7'h45};
  check_dev_addr(dyn, virt, "SETNEWDA on virtual address");
  @(negedge clk);
  set_dasa       = 7'h5a;
  set_dasa_valid = 1'b1;
  end_ccc();
  dyn = '{valid: 1'b1, addr: 7'h5a};
  check_dev_addr(dyn, virt, "SETDASA on dynamic address");
  @(negedge clk);
  rstdaa    = 1'b1;
  newda     = 7'h11;
  set_newda = 1'b1;
  end_ccc();
  dyn  = '{valid: 1'b0, addr: '0};  // RSTDAA wins over SETNEWDA
  virt = '{valid: 1'b0, addr: '0};
  check_dev_addr(dyn, virt, "RSTDAA with SETNEWDA");
endtask

`endif

// File: tb_hci.sv
/* HCI queue and CSR testbench */
`timescale 1ns/100ps

module tb_hci
  import i3c_hci_pkg::*;
();

  localparam int unsigned Depth = 8;

  // Cycle budget per test, doubled for the timeout
  localparam int unsigned ResetCycles        = 10;
  localparam int unsigned CmdPathCycles      = 30;
  localparam int unsigned BackPressureCycles = 60;
  localparam int unsigned RespPathCycles     = 16;
  localparam int unsigned ThldResetCycles    = 48;
  localparam int unsigned AddrCycles         = 26;
  localparam int unsigned TestCycles         = ResetCycles + CmdPathCycles +
                                               BackPressureCycles + RespPathCycles +
                                               ThldResetCycles + AddrCycles;
  localparam int unsigned TimeoutCycles      = 2 * TestCycles;

  logic                    clk;
  logic                    rst_n;

  logic                    csr_req;
  logic                    csr_we;
  logic [CsrAddrWidth-1:0] csr_addr;
  logic [CsrDataWidth-1:0] csr_wdata;
  logic                    req_stall_wr;
  logic                    rd_ack;
  logic                    rd_err;
  logic [CsrDataWidth-1:0] rd_data;
  logic                    wr_ack;

  logic                    cmd_rvalid;
  logic                    cmd_rready;
  cmd_desc_t               cmd_rdata;
  logic                    resp_wvalid;
  logic                    resp_wready;
  resp_desc_t              resp_wdata;
  logic                    cmd_trig;
  logic                    resp_trig;

  logic [DevAddrWidth-1:0] set_dasa;
  logic                    set_dasa_valid;
  logic                    set_dasa_virt;
  logic                    rstdaa;
  logic [DevAddrWidth-1:0] newda;
  logic                    set_newda;
  logic                    set_newda_virt;
  logic                    set_aasa;
  logic                    set_aasa_virt;

  int unsigned             checks     = 0;
  int unsigned             mismatches = 0;
  int unsigned             failures   = 0;
  int unsigned             cycle_cnt  = 0;
  logic [31:0]             lcg_state  = 32'h6a35_933d;

  tb_clk_gen #(.HalfPeriod(10), .ResetCycles(8)) u_clk_gen (
    .clk_o(clk), .rst_no(rst_n)
  );

  hci_top #(.CmdDepth(Depth), .RespDepth(Depth)) u_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(csr_req), .req_is_wr_i(csr_we), .addr_i(csr_addr), .wr_data_i(csr_wdata),
    .req_stall_wr_o(req_stall_wr), .rd_ack_o(rd_ack), .rd_err_o(rd_err),
    .rd_data_o(rd_data), .wr_ack_o(wr_ack),
    .cmd_rvalid_o(cmd_rvalid), .cmd_rready_i(cmd_rready), .cmd_rdata_o(cmd_rdata),
    .resp_wvalid_i(resp_wvalid), .resp_wready_o(resp_wready), .resp_wdata_i(resp_wdata),
    .cmd_thld_trig_o(cmd_trig), .resp_thld_trig_o(resp_trig),
    .set_dasa_i(set_dasa), .set_dasa_valid_i(set_dasa_valid), .set_dasa_virt_i(set_dasa_virt),
    .rstdaa_i(rstdaa), .newda_i(newda), .set_newda_i(set_newda),
    .set_newda_virt_i(set_newda_virt), .set_aasa_i(set_aasa), .set_aasa_virt_i(set_aasa_virt)
  );

  // Payload source
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_hci_tasks.svh"

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("checks: %0d, mismatches: %0d, other errors: %0d",
               checks, mismatches, failures + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    drive_idle();
    check_reset_values();
    @(posedge rst_n);
    @(negedge clk);
    cmd_path_test();
    back_pressure_test();
    resp_path_test();
    thld_reset_test();
    addr_test();
    repeat (2) @(negedge clk);
    $display("checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_hci

// File: list.f
+incdir+.
i3c_hci_pkg.sv
hci_queue_if.sv
hci_csr_decode.sv
hci_queue.sv
hci_addr_ctrl.sv
hci_csr_readback.sv
hci_top.sv
tb_clk_gen.sv
tb_hci.sv
